// ==== source/dft_pkg.sv ====
package dft_pkg;

    // Transform size
    localparam int N_POINTS = 64;
    localparam int LOG2_N   = 6;
    localparam int N_WORDS  = 32;
    localparam int SAMPLE_W = 16;

    // Twiddles are Q1.15
    localparam int  TWIDDLE_FRAC = 15;
    localparam real PI           = 3.14159265358979323846;

    // Word addresses on wb_adr_i[3:0]
    localparam logic [3:0] REG_START    = 4'd0;
    localparam logic [3:0] REG_WRITE    = 4'd1;
    localparam logic [3:0] REG_IN_ADDR  = 4'd2;
    localparam logic [3:0] REG_IN_LO    = 4'd3;
    localparam logic [3:0] REG_IN_HI    = 4'd4;
    localparam logic [3:0] REG_OUT_ADDR = 4'd5;
    localparam logic [3:0] REG_OUT_LO   = 4'd6;
    localparam logic [3:0] REG_OUT_HI   = 4'd7;
    localparam logic [3:0] REG_VALID    = 4'd8;

    // Controller state codes
    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_LOAD  = 3'd1;
    localparam logic [2:0] S_READ  = 3'd2;
    localparam logic [2:0] S_COMP  = 3'd3;
    localparam logic [2:0] S_WRITE = 3'd4;
    localparam logic [2:0] S_DONE  = 3'd5;

    // One buffer word, seen by the bus as two halves or as two samples
    typedef union packed {
        struct packed {
            logic [31:0] hi;
            logic [31:0] lo;
        } bus;
        struct packed {
            logic [SAMPLE_W-1:0] im1;
            logic [SAMPLE_W-1:0] re1;
            logic [SAMPLE_W-1:0] im0;
            logic [SAMPLE_W-1:0] re0;
        } smp;
    } sample_word_u;

endpackage

// ==== source/dft_wb_regs.sv ====
`timescale 1ns/1ps

module dft_wb_regs
    import dft_pkg::*;
(
    input  logic              wb_clk_i,
    input  logic              wb_rst_i,
    input  logic [31:0]       wb_adr_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [31:0]       wb_dat_i,
    output logic [31:0]       wb_dat_o,
    output logic              wb_ack_o,
    output logic              start_o,
    output logic              in_we_o,
    output logic [LOG2_N-2:0] in_addr_o,
    output sample_word_u      in_data_o,
    output logic [LOG2_N-2:0] out_addr_o,
    input  sample_word_u      out_data_i,
    input  logic              data_valid_i
);
    logic        start_reg;
    logic        start_q;
    logic        write_reg;
    logic        write_q;
    logic [31:0] in_addr_reg;
    logic [31:0] out_addr_reg;
    logic        bus_wr;

    assign bus_wr   = wb_stb_i & wb_we_i;
    assign wb_ack_o = wb_cyc_i & wb_stb_i;

    always_ff @(posedge wb_clk_i)
    begin
        if (wb_rst_i)
        begin
            start_reg    <= 1'b0;
            start_q      <= 1'b0;
            write_reg    <= 1'b0;
            write_q      <= 1'b0;
            in_addr_reg  <= '0;
            out_addr_reg <= '0;
        end
        else
        begin
            start_q <= start_reg;
            write_q <= write_reg;
            if (bus_wr)
            begin
                case (wb_adr_i[3:0])
                    REG_START:    start_reg    <= wb_dat_i[0];
                    REG_WRITE:    write_reg    <= wb_dat_i[0];
                    REG_IN_ADDR:  in_addr_reg  <= wb_dat_i;
                    REG_OUT_ADDR: out_addr_reg <= wb_dat_i;
                    default:      ;
                endcase
            end
        end
    end

    // Input sample word
    always_ff @(posedge wb_clk_i)
    begin
        if (bus_wr && wb_adr_i[3:0] == REG_IN_LO)
            in_data_o.bus.lo <= wb_dat_i;
        if (bus_wr && wb_adr_i[3:0] == REG_IN_HI)
            in_data_o.bus.hi <= wb_dat_i;
    end

    // Controls act on the rising edge of their register
    assign start_o    = start_reg & ~start_q;
    assign in_we_o    = write_reg & ~write_q;
    assign in_addr_o  = in_addr_reg[LOG2_N-2:0];
    assign out_addr_o = out_addr_reg[LOG2_N-2:0];

    always_comb
    begin
        case (wb_adr_i[3:0])
            REG_START:    wb_dat_o = {31'b0, start_reg};
            REG_WRITE:    wb_dat_o = {31'b0, write_reg};
            REG_IN_ADDR:  wb_dat_o = in_addr_reg;
            REG_IN_LO:    wb_dat_o = in_data_o.bus.lo;
            REG_IN_HI:    wb_dat_o = in_data_o.bus.hi;
            REG_OUT_ADDR: wb_dat_o = out_addr_reg;
            REG_OUT_LO:   wb_dat_o = out_data_i.bus.lo;
            REG_OUT_HI:   wb_dat_o = out_data_i.bus.hi;
            REG_VALID:    wb_dat_o = {31'b0, data_valid_i};
            default:      wb_dat_o = '0;
        endcase
    end

endmodule

// ==== source/dft_in_buf.sv ====
`timescale 1ns/1ps

module dft_in_buf
    import dft_pkg::*;
(
    input  logic              wb_clk_i,
    input  logic              we_i,
    input  logic [LOG2_N-2:0] waddr_i,
    input  sample_word_u      wdata_i,
    input  logic [LOG2_N-2:0] raddr_i,
    output sample_word_u      rdata_o
);
    sample_word_u mem [N_WORDS];

    always_ff @(posedge wb_clk_i)
    begin
        if (we_i)
            mem[waddr_i] <= wdata_i;
        rdata_o <= mem[raddr_i];
    end

    // The loader steps the read address each cycle; the host stays clear of it
    a_no_collision: assert property (@(posedge wb_clk_i)
        (raddr_i != $past(raddr_i)) |-> !(we_i && waddr_i == raddr_i));

endmodule

// ==== source/dft_work_ram.sv ====
`timescale 1ns/1ps

module dft_work_ram
    import dft_pkg::*;
(
    input  logic                  wb_clk_i,
    input  logic                  load_we_i,
    input  logic [LOG2_N-1:0]     load_idx0_i,
    input  logic [LOG2_N-1:0]     load_idx1_i,
    input  sample_word_u          load_word_i,
    input  logic [LOG2_N-1:0]     rd_a_idx_i,
    input  logic [LOG2_N-1:0]     rd_b_idx_i,
    output logic [2*SAMPLE_W-1:0] rd_a_o,
    output logic [2*SAMPLE_W-1:0] rd_b_o,
    input  logic                  wr_we_i,
    input  logic [2*SAMPLE_W-1:0] wr_a_i,
    input  logic [2*SAMPLE_W-1:0] wr_b_i,
    input  logic [LOG2_N-2:0]     host_addr_i,
    output sample_word_u          host_word_o
);
    // Each entry is {im, re}
    logic [2*SAMPLE_W-1:0] mem [N_POINTS];

    always_ff @(posedge wb_clk_i)
    begin
        if (load_we_i)
        begin
            mem[load_idx0_i] <= {load_word_i.smp.im0, load_word_i.smp.re0};
            mem[load_idx1_i] <= {load_word_i.smp.im1, load_word_i.smp.re1};
        end
        else if (wr_we_i)
        begin
            mem[rd_a_idx_i] <= wr_a_i;
            mem[rd_b_idx_i] <= wr_b_i;
        end
        rd_a_o <= mem[rd_a_idx_i];
        rd_b_o <= mem[rd_b_idx_i];
    end

    assign host_word_o = {mem[{host_addr_i, 1'b1}], mem[{host_addr_i, 1'b0}]};

endmodule

// ==== source/dft_twiddle_rom.sv ====
`timescale 1ns/1ps

module dft_twiddle_rom
    import dft_pkg::*;
(
    input  logic                       wb_clk_i,
    input  logic [LOG2_N-2:0]          idx_i,
    output logic signed [SAMPLE_W-1:0] cos_o,
    output logic signed [SAMPLE_W-1:0] nsin_o
);
    logic signed [SAMPLE_W-1:0] cos_tab  [N_POINTS/2];
    logic signed [SAMPLE_W-1:0] nsin_tab [N_POINTS/2];

    // Round to nearest, clip at the Q1.15 limits
    function automatic logic signed [SAMPLE_W-1:0] to_fixed(input real v);
        real scaled;
        scaled = v * (2.0 ** TWIDDLE_FRAC);
        if (scaled >= 2.0 ** (SAMPLE_W - 1) - 1.0)
            return {1'b0, {(SAMPLE_W-1){1'b1}}};
        if (scaled <= -(2.0 ** (SAMPLE_W - 1)))
            return {1'b1, {(SAMPLE_W-1){1'b0}}};
        return SAMPLE_W'($rtoi(scaled >= 0.0 ? scaled + 0.5 : scaled - 0.5));
    endfunction

    for (genvar k = 0; k < N_POINTS / 2; k++)
    begin : g_tab
        localparam real ANGLE = 2.0 * PI * k / N_POINTS;
        assign cos_tab[k]  = to_fixed($cos(ANGLE));
        assign nsin_tab[k] = to_fixed(-$sin(ANGLE));
    end

    always_ff @(posedge wb_clk_i)
    begin
        cos_o  <= cos_tab[idx_i];
        nsin_o <= nsin_tab[idx_i];
    end

endmodule

// ==== source/dft_butterfly.sv ====
`timescale 1ns/1ps

module dft_butterfly
    import dft_pkg::*;
(
    input  logic signed [SAMPLE_W-1:0] a_re_i,
    input  logic signed [SAMPLE_W-1:0] a_im_i,
    input  logic signed [SAMPLE_W-1:0] b_re_i,
    input  logic signed [SAMPLE_W-1:0] b_im_i,
    input  logic signed [SAMPLE_W-1:0] w_re_i,
    input  logic signed [SAMPLE_W-1:0] w_im_i,
    input  logic                       bypass_i,
    output logic signed [SAMPLE_W-1:0] top_re_o,
    output logic signed [SAMPLE_W-1:0] top_im_o,
    output logic signed [SAMPLE_W-1:0] bot_re_o,
    output logic signed [SAMPLE_W-1:0] bot_im_o
);
    logic signed [2*SAMPLE_W-1:0] p_rr;
    logic signed [2*SAMPLE_W-1:0] p_ii;
    logic signed [2*SAMPLE_W-1:0] p_ri;
    logic signed [2*SAMPLE_W-1:0] p_ir;
    logic signed [2*SAMPLE_W:0]   m_re;
    logic signed [2*SAMPLE_W:0]   m_im;
    logic signed [SAMPLE_W-1:0]   t_re;
    logic signed [SAMPLE_W-1:0]   t_im;
    logic signed [SAMPLE_W:0]     sum_re;
    logic signed [SAMPLE_W:0]     sum_im;
    logic signed [SAMPLE_W:0]     dif_re;
    logic signed [SAMPLE_W:0]     dif_im;

    // t = b * w, back to sample scale
    assign p_rr = b_re_i * w_re_i;
    assign p_ii = b_im_i * w_im_i;
    assign p_ri = b_re_i * w_im_i;
    assign p_ir = b_im_i * w_re_i;
    assign m_re = p_rr - p_ii;
    assign m_im = p_ri + p_ir;

    // W^0 is exactly one and has no Q1.15 code
    assign t_re = bypass_i ? b_re_i : SAMPLE_W'(m_re >>> TWIDDLE_FRAC);
    assign t_im = bypass_i ? b_im_i : SAMPLE_W'(m_im >>> TWIDDLE_FRAC);

    assign sum_re = a_re_i + t_re;
    assign sum_im = a_im_i + t_im;
    assign dif_re = a_re_i - t_re;
    assign dif_im = a_im_i - t_im;

    // Halve every output so the full transform stays in range
    assign top_re_o = sum_re[SAMPLE_W:1];
    assign top_im_o = sum_im[SAMPLE_W:1];
    assign bot_re_o = dif_re[SAMPLE_W:1];
    assign bot_im_o = dif_im[SAMPLE_W:1];

endmodule

// ==== source/dft_ctrl.sv ====
`timescale 1ns/1ps

module dft_ctrl
    import dft_pkg::*;
(
    input  logic              wb_clk_i,
    input  logic              wb_rst_i,
    input  logic              start_i,
    output logic [LOG2_N-2:0] ld_addr_o,
    output logic              load_we_o,
    output logic [LOG2_N-1:0] load_idx0_o,
    output logic [LOG2_N-1:0] load_idx1_o,
    output logic [LOG2_N-1:0] rd_a_idx_o,
    output logic [LOG2_N-1:0] rd_b_idx_o,
    output logic              wr_we_o,
    output logic [LOG2_N-2:0] tw_idx_o,
    output logic              bypass_o,
    output logic              busy_o,
    output logic              data_valid_o,
    output logic              done_o
);
    logic [2:0]        state;
    logic [LOG2_N-2:0] cnt;
    logic [2:0]        stage;
    logic [LOG2_N-1:0] half;
    logic [LOG2_N-2:0] j_idx;
    logic [LOG2_N-1:0] base;

    always_ff @(posedge wb_clk_i)
    begin
        if (wb_rst_i)
        begin
            state        <= S_IDLE;
            cnt          <= '0;
            stage        <= '0;
            data_valid_o <= 1'b0;
        end
        else if (start_i)
        begin
            // Also aborts a run in progress
            state        <= S_LOAD;
            cnt          <= '0;
            stage        <= '0;
            data_valid_o <= 1'b0;
        end
        else
        begin
            case (state)
                S_LOAD:
                begin
                    cnt <= cnt + 1'b1;
                    if (&cnt)
                        state <= S_READ;
                end
                S_READ:  state <= S_COMP;
                S_COMP:  state <= S_WRITE;
                S_WRITE:
                begin
                    cnt <= cnt + 1'b1;
                    if (&cnt && stage == 3'(LOG2_N - 1))
                    begin
                        state        <= S_DONE;
                        data_valid_o <= 1'b1;
                    end
                    else
                    begin
                        state <= S_READ;
                        if (&cnt)
                            stage <= stage + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Buffer read runs one word ahead, word 0 is already addressed while idle
    assign ld_addr_o   = (state == S_LOAD && !start_i) ? cnt + 1'b1 : '0;
    assign load_we_o   = (state == S_LOAD);
    assign load_idx0_o = {<<{cnt, 1'b0}};
    assign load_idx1_o = {<<{cnt, 1'b1}};

    // Butterfly k of stage s: j = k mod 2^s, a = 2(k - j) + j, b = a + 2^s
    assign half       = LOG2_N'(1) << stage;
    assign j_idx      = cnt & (half[LOG2_N-2:0] - 1'b1);
    assign base       = {cnt - j_idx, 1'b0};
    assign rd_a_idx_o = base + j_idx;
    assign rd_b_idx_o = rd_a_idx_o + half;
    assign tw_idx_o   = j_idx << ((LOG2_N - 1) - stage);
    assign bypass_o   = (tw_idx_o == '0);

    assign wr_we_o = (state == S_WRITE);
    assign busy_o  = (state == S_LOAD) || (state == S_READ) ||
                     (state == S_COMP) || (state == S_WRITE);
    assign done_o  = (state == S_DONE);

    a_valid_not_busy: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        !(busy_o && data_valid_o));

endmodule

// ==== source/dft_wb_top.sv ====
`timescale 1ns/1ps

module dft_wb_top
    import dft_pkg::*;
(
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic [31:0] wb_adr_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [3:0]  wb_sel_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic        int_o
);
    // Byte selects unused, every register is word wide
    logic                       start;
    logic                       in_we;
    logic [LOG2_N-2:0]          in_addr;
    sample_word_u               in_data;
    logic [LOG2_N-2:0]          out_addr;
    sample_word_u               out_data;
    logic                       data_valid;
    logic [LOG2_N-2:0]          ld_addr;
    sample_word_u               ld_word;
    logic                       load_we;
    logic [LOG2_N-1:0]          load_idx0;
    logic [LOG2_N-1:0]          load_idx1;
    logic [LOG2_N-1:0]          rd_a_idx;
    logic [LOG2_N-1:0]          rd_b_idx;
    logic [2*SAMPLE_W-1:0]      rd_a;
    logic [2*SAMPLE_W-1:0]      rd_b;
    logic                       wr_we;
    logic [LOG2_N-2:0]          tw_idx;
    logic                       bypass;
    logic signed [SAMPLE_W-1:0] w_re;
    logic signed [SAMPLE_W-1:0] w_im;
    logic signed [SAMPLE_W-1:0] top_re;
    logic signed [SAMPLE_W-1:0] top_im;
    logic signed [SAMPLE_W-1:0] bot_re;
    logic signed [SAMPLE_W-1:0] bot_im;

    dft_wb_regs i_regs (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .wb_adr_i     (wb_adr_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .start_o      (start),
        .in_we_o      (in_we),
        .in_addr_o    (in_addr),
        .in_data_o    (in_data),
        .out_addr_o   (out_addr),
        .out_data_i   (out_data),
        .data_valid_i (data_valid)
    );

    dft_in_buf i_in_buf (
        .wb_clk_i (wb_clk_i),
        .we_i     (in_we),
        .waddr_i  (in_addr),
        .wdata_i  (in_data),
        .raddr_i  (ld_addr),
        .rdata_o  (ld_word)
    );

    dft_work_ram i_work_ram (
        .wb_clk_i    (wb_clk_i),
        .load_we_i   (load_we),
        .load_idx0_i (load_idx0),
        .load_idx1_i (load_idx1),
        .load_word_i (ld_word),
        .rd_a_idx_i  (rd_a_idx),
        .rd_b_idx_i  (rd_b_idx),
        .rd_a_o      (rd_a),
        .rd_b_o      (rd_b),
        .wr_we_i     (wr_we),
        .wr_a_i      ({top_im, top_re}),
        .wr_b_i      ({bot_im, bot_re}),
        .host_addr_i (out_addr),
        .host_word_o (out_data)
    );

    dft_twiddle_rom i_twiddle_rom (
        .wb_clk_i (wb_clk_i),
        .idx_i    (tw_idx),
        .cos_o    (w_re),
        .nsin_o   (w_im)
    );

    dft_butterfly i_butterfly (
        .a_re_i   (rd_a[SAMPLE_W-1:0]),
        .a_im_i   (rd_a[2*SAMPLE_W-1:SAMPLE_W]),
        .b_re_i   (rd_b[SAMPLE_W-1:0]),
        .b_im_i   (rd_b[2*SAMPLE_W-1:SAMPLE_W]),
        .w_re_i   (w_re),
        .w_im_i   (w_im),
        .bypass_i (bypass),
        .top_re_o (top_re),
        .top_im_o (top_im),
        .bot_re_o (bot_re),
        .bot_im_o (bot_im)
    );

    dft_ctrl i_ctrl (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .start_i      (start),
        .ld_addr_o    (ld_addr),
        .load_we_o    (load_we),
        .load_idx0_o  (load_idx0),
        .load_idx1_o  (load_idx1),
        .rd_a_idx_o   (rd_a_idx),
        .rd_b_idx_o   (rd_b_idx),
        .wr_we_o      (wr_we),
        .tw_idx_o     (tw_idx),
        .bypass_o     (bypass),
        .busy_o       (),
        .data_valid_o (data_valid),
        .done_o       (int_o)
    );

endmodule

// ==== tests/dft_tb.sv ====
`timescale 1ns/1ps

module dft_tb;

    // Host view of the register map
    localparam logic [31:0] REG_START    = 32'd0;
    localparam logic [31:0] REG_WRITE    = 32'd1;
    localparam logic [31:0] REG_IN_ADDR  = 32'd2;
    localparam logic [31:0] REG_IN_LO    = 32'd3;
    localparam logic [31:0] REG_IN_HI    = 32'd4;
    localparam logic [31:0] REG_OUT_ADDR = 32'd5;
    localparam logic [31:0] REG_OUT_LO   = 32'd6;
    localparam logic [31:0] REG_OUT_HI   = 32'd7;
    localparam logic [31:0] REG_VALID    = 32'd8;
    localparam logic [31:0] REG_UNUSED   = 32'd12;
    localparam int          POLL_LIMIT   = 2000;
    localparam int          N_TESTS      = 8;

    logic        wb_clk_i;
    logic        wb_rst_i;
    logic [31:0] wb_adr_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        int_o;

    logic [31:0] rng_state;
    int          irq_count;
    int          runs_done;

    // Stimulus and expected bins per test
    string t_name [N_TESTS];
    int    t_amp  [N_TESTS];
    int    t_dc   [N_TESTS];
    bit    t_rep  [N_TESTS];
    int    t_exp0 [N_TESTS];
    int    t_exp  [N_TESTS];

    dft_wb_top i_dft_wb_top (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .wb_adr_i (wb_adr_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_sel_i (wb_sel_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .int_o    (int_o)
    );

    initial
    begin
        wb_clk_i = 1'b0;
        forever #20 wb_clk_i = ~wb_clk_i;
    end

    // int_o lasts one cycle, so each completion counts once
    always @(negedge wb_clk_i)
    begin
        if (int_o === 1'b1)
            irq_count = irq_count + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Uniform value in -limit to +limit
    task automatic draw(input int limit, output int val);
        rng_state = xorshift(rng_state);
        val = int'(rng_state % (2 * limit + 1)) - limit;
    endtask

    task automatic check_word(input string test, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("Mismatch in %s, %s: expected %h, actual %h", test, what, exp, act);
            $display("TEST FAILED");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic check_ack(input logic [31:0] adr);
        assert (wb_ack_o === 1'b1)
        else
        begin
            $display("Bus access to address %0d was not acknowledged", adr);
            $display("TEST FAILED");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    // Each access starts 2 ns after an edge and lasts one cycle
    task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat);
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_we_i  = 1'b1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        @(negedge wb_clk_i);
        check_ack(adr);
        @(posedge wb_clk_i);
        #2;
        wb_we_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [31:0] dat);
        wb_adr_i = adr;
        wb_we_i  = 1'b0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        @(negedge wb_clk_i);
        check_ack(adr);
        dat = wb_dat_o;
        @(posedge wb_clk_i);
        #2;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    task automatic wait_valid(input string test);
        logic [31:0] val;
        int          polls;
        val   = '0;
        polls = 0;
        while (val[0] !== 1'b1 && polls < POLL_LIMIT)
        begin
            bus_read(REG_VALID, val);
            polls++;
        end
        assert (val[0] === 1'b1)
        else
        begin
            $display("The transform in %s never completed, valid stayed low for %0d polls",
                     test, polls);
            $display("TEST FAILED");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    // Sample 0 holds A + C, every other sample C, equal in re and im
    task automatic fill_input(input int amp, input int dc);
        logic [15:0] s0;
        logic [15:0] s1;
        for (int w = 0; w < 32; w++)
        begin
            s0 = (w == 0) ? 16'(amp + dc) : 16'(dc);
            s1 = 16'(dc);
            bus_write(REG_IN_ADDR, 32'(w));
            bus_write(REG_IN_LO, {s0, s0});
            bus_write(REG_IN_HI, {s1, s1});
            bus_write(REG_WRITE, 32'd1);
            bus_write(REG_WRITE, 32'd0);
        end
    endtask

    task automatic pulse_start(input string test);
        logic [31:0] val;
        bus_write(REG_START, 32'd1);
        bus_write(REG_START, 32'd0);
        bus_read(REG_VALID, val);
        check_word(test, "valid while running", 32'd0, val);
        runs_done++;
    endtask

    task automatic run_and_check(input int t);
        logic [31:0] lo;
        logic [31:0] hi;
        logic [15:0] b0;
        logic [15:0] bn;
        pulse_start(t_name[t]);
        wait_valid(t_name[t]);
        bn = 16'(t_exp[t]);
        for (int k = 0; k < 32; k++)
        begin
            b0 = (k == 0) ? 16'(t_exp0[t]) : bn;
            bus_write(REG_OUT_ADDR, 32'(k));
            bus_read(REG_OUT_LO, lo);
            bus_read(REG_OUT_HI, hi);
            check_word(t_name[t], $sformatf("bin %0d", 2 * k), {b0, b0}, lo);
            check_word(t_name[t], $sformatf("bin %0d", 2 * k + 1), {bn, bn}, hi);
        end
        check_word(t_name[t], "interrupt count", 32'(runs_done), 32'(irq_count));
    endtask

    task automatic check_registers();
        logic [31:0] val;
        logic [31:0] pattern;
        bus_read(REG_VALID, val);
        check_word("registers", "valid after reset", 32'd0, val);
        bus_read(REG_UNUSED, val);
        check_word("registers", "unused address 12", 32'd0, val);
        bus_write(REG_WRITE, 32'd1);
        bus_read(REG_WRITE, val);
        check_word("registers", "register 1 set", 32'd1, val);
        bus_write(REG_WRITE, 32'd0);
        bus_read(REG_WRITE, val);
        check_word("registers", "register 1 clear", 32'd0, val);
        for (int r = 2; r <= 5; r++)
        begin
            rng_state = xorshift(rng_state);
            pattern   = rng_state;
            bus_write(32'(r), pattern);
            bus_read(32'(r), val);
            check_word("registers", $sformatf("register %0d", r), pattern, val);
        end
        // Setting the start register also launches a transform
        bus_write(REG_START, 32'd1);
        bus_read(REG_START, val);
        check_word("registers", "register 0 set", 32'd1, val);
        bus_write(REG_START, 32'd0);
        bus_read(REG_START, val);
        check_word("registers", "register 0 clear", 32'd0, val);
        runs_done++;
        wait_valid("registers");
    endtask

    task automatic add_test(input int t, input string name, input int amp,
                            input int dc, input bit rep);
        t_name[t] = name;
        t_amp[t]  = amp;
        t_dc[t]   = dc;
        t_rep[t]  = rep;
        // Each stage halves, so the sum over 64 points is divided by 64
        t_exp0[t] = amp / 64 + dc;
        t_exp[t]  = amp / 64;
    endtask

    task automatic build_table();
        int a;
        int c;
        add_test(0, "impulse", 8192, 0, 1'b0);
        add_test(1, "impulse_neg", -12800, 0, 1'b0);
        add_test(2, "dc", 0, 1234, 1'b0);
        add_test(3, "dc_neg", 0, -777, 1'b0);
        add_test(4, "zero", 0, 0, 1'b0);
        for (int t = 5; t < N_TESTS; t++)
        begin
            draw(250, a);
            draw(8000, c);
            add_test(t, $sformatf("random_%0d", t - 5), a * 64, c, t == N_TESTS - 1);
        end
    endtask

    initial
    begin
        logic [31:0] val;
        wb_rst_i  = 1'b1;
        wb_adr_i  = '0;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_sel_i  = 4'hf;
        wb_dat_i  = '0;
        rng_state = 32'h43dd_2f81;
        irq_count = 0;
        runs_done = 0;
        build_table();
        repeat (10) @(posedge wb_clk_i);
        #2;
        wb_rst_i = 1'b0;

        check_registers();
        for (int t = 0; t < N_TESTS; t++)
        begin
            fill_input(t_amp[t], t_dc[t]);
            run_and_check(t);
            if (t_rep[t])
            begin
                // Rerun on the same buffer contents
                bus_read(REG_VALID, val);
                check_word(t_name[t], "valid before restart", 32'd1, val);
                run_and_check(t);
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== sources.f ====
source/dft_pkg.sv
source/dft_wb_regs.sv
source/dft_in_buf.sv
source/dft_work_ram.sv
source/dft_twiddle_rom.sv
source/dft_butterfly.sv
source/dft_ctrl.sv
source/dft_wb_top.sv
tests/dft_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dft_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
